//--- list.f
logic/exec_pkg.sv
logic/lane_issue_if.sv
logic/lane_result_if.sv
logic/issue_dispatch.sv
logic/alu_lane.sv
logic/completion_arbiter.sv
logic/alu_cluster.sv
verification/alu_cluster_tb.sv

//--- logic/alu_cluster.sv
`default_nettype none

module alu_cluster (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    issue_req,
    input  exec_pkg::issue_packet_t issue_packet,
    output logic                    issue_ack,
    output logic                    result_req,
    input  logic                    result_ack,
    output exec_pkg::tag_t          result_tag,
    output exec_pkg::word_t         result_data
);
    import exec_pkg::*;

    lane_issue_if  issue_lanes  [num_lanes] ();
    lane_result_if result_lanes [num_lanes] ();

    issue_dispatch u_issue_dispatch (
        .clock        (clock),
        .reset        (reset),
        .issue_req    (issue_req),
        .issue_packet (issue_packet),
        .issue_ack    (issue_ack),
        .lanes        (issue_lanes)
    );

    // one packet in flight per lane
    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        alu_lane u_alu_lane (
            .clock  (clock),
            .reset  (reset),
            .issue  (issue_lanes[i]),
            .result (result_lanes[i])
        );
    end

    completion_arbiter u_completion_arbiter (
        .clock       (clock),
        .reset       (reset),
        .lanes       (result_lanes),
        .result_req  (result_req),
        .result_ack  (result_ack),
        .result_tag  (result_tag),
        .result_data (result_data)
    );

endmodule

`default_nettype wire

//--- logic/alu_lane.sv
`default_nettype none

module alu_lane (
    input logic         clock,
    input logic         reset,
    lane_issue_if.lane  issue,
    lane_result_if.lane result
);
    import exec_pkg::*;

    lane_state_e   state;
    issue_packet_t pkt;
    word_t         inst;
    word_t         opa;
    word_t         opb;
    word_t         alu_out;
    alu_result_t   result_r;
    logic          ack_r;
    logic          req_r;

    assign pkt  = issue.packet;
    assign inst = pkt.inst;

    always_comb begin
        case (pkt.opa_select)
            opa_rs1:  opa = pkt.rs1_value;
            opa_npc:  opa = pkt.pc + 32'd4;
            opa_pc:   opa = pkt.pc;
            opa_zero: opa = '0;
            default:  opa = opa_marker;
        endcase
    end

    // immediates per the RV32 encodings
    always_comb begin
        case (pkt.opb_select)
            opb_rs2:   opb = pkt.rs2_value;
            opb_i_imm: opb = {{20{inst[31]}}, inst[31:20]};
            opb_s_imm: opb = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            opb_b_imm: opb = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            opb_u_imm: opb = {inst[31:12], 12'b0};
            opb_j_imm: opb = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:   opb = opb_marker;
        endcase
    end

    always_comb begin
        case (pkt.func)
            alu_add:  alu_out = opa + opb;
            alu_sub:  alu_out = opa - opb;
            alu_and:  alu_out = opa & opb;
            alu_or:   alu_out = opa | opb;
            alu_xor:  alu_out = opa ^ opb;
            alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(opa) < $signed(opb)};
            alu_sltu: alu_out = {{(xlen-1){1'b0}}, opa < opb};
            alu_sll:  alu_out = opa << opb[4:0];
            alu_srl:  alu_out = opa >> opb[4:0];
            alu_sra:  alu_out = word_t'($signed(opa) >>> opb[4:0]);
            default:  alu_out = func_marker;
        endcase
    end

    assign issue.idle    = (state == lane_idle);
    assign issue.ack     = ack_r;
    assign result.req    = req_r;
    assign result.result = result_r;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= lane_idle;
            ack_r <= 1'b0;
            req_r <= 1'b0;
        end else begin
            case (state)
                lane_idle: begin
                    if (issue.req) begin
                        ack_r <= 1'b1;
                        state <= lane_issue_hold;
                    end
                end
                lane_issue_hold: begin
                    if (!issue.req) begin
                        ack_r <= 1'b0;
                        req_r <= 1'b1;    // result offered as issue closes
                        state <= lane_result_wait;
                    end
                end
                lane_result_wait: begin
                    if (result.ack) begin
                        req_r <= 1'b0;
                        state <= lane_result_release;
                    end
                end
                lane_result_release: begin
                    if (!result.ack) state <= lane_idle;
                end
                default: state <= lane_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == lane_idle && issue.req) begin
            result_r.tag  <= pkt.tag;
            result_r.data <= alu_out;
        end
    end

endmodule

`default_nettype wire

//--- logic/completion_arbiter.sv
`default_nettype none

module completion_arbiter (
    input  logic             clock,
    input  logic             reset,
    lane_result_if.arbiter   lanes [exec_pkg::num_lanes],
    output logic             result_req,
    input  logic             result_ack,
    output exec_pkg::tag_t   result_tag,
    output exec_pkg::word_t  result_data
);
    import exec_pkg::*;

    arb_state_e               state;
    logic [num_lanes-1:0]     req_vec;
    alu_result_t              lane_res [num_lanes];
    logic [lane_idx_bits-1:0] grant;
    logic [lane_idx_bits-1:0] last_grant;
    logic [lane_idx_bits-1:0] pick;
    logic                     any_req;
    logic                     lane_ack;
    alu_result_t              out_r;

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        assign req_vec[i]   = lanes[i].req;
        assign lane_res[i]  = lanes[i].result;
        assign lanes[i].ack = lane_ack && (grant == lane_idx_bits'(i));
    end

    // search begins just past the last grant
    always_comb begin
        int idx;
        any_req = 1'b0;
        pick    = last_grant;
        for (int k = num_lanes; k >= 1; k--) begin
            idx = (int'(last_grant) + k) % num_lanes;
            if (req_vec[idx]) begin
                any_req = 1'b1;
                pick    = lane_idx_bits'(idx);
            end
        end
    end

    assign result_tag  = out_r.tag;
    assign result_data = out_r.data;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= arb_scan;
            grant      <= '0;
            last_grant <= lane_idx_bits'(num_lanes - 1);   // lane 0 first
            lane_ack   <= 1'b0;
            result_req <= 1'b0;
        end else begin
            case (state)
                arb_scan: begin
                    if (any_req) begin
                        grant      <= pick;
                        result_req <= 1'b1;
                        state      <= arb_offer;
                    end
                end
                arb_offer: begin
                    if (result_ack) begin
                        lane_ack <= 1'b1;
                        state    <= arb_drop;
                    end
                end
                arb_drop: begin
                    if (!req_vec[grant]) begin
                        lane_ack   <= 1'b0;
                        result_req <= 1'b0;
                        last_grant <= grant;
                        state      <= arb_settle;
                    end
                end
                arb_settle: begin
                    if (!result_ack) state <= arb_scan;
                end
                default: state <= arb_scan;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == arb_scan && any_req) out_r <= lane_res[pick];
    end

endmodule

`default_nettype wire

//--- logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int xlen          = 32;
    localparam int tag_bits      = 6;
    localparam int num_lanes     = 4;
    localparam int lane_idx_bits = $clog2(num_lanes);

    typedef logic [xlen-1:0]     word_t;
    typedef logic [tag_bits-1:0] tag_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_func_e;

    typedef enum logic [1:0] {
        opa_rs1  = 2'd0,
        opa_npc  = 2'd1,
        opa_pc   = 2'd2,
        opa_zero = 2'd3
    } opa_select_e;

    // codes 6 and 7 are left undefined
    typedef enum logic [2:0] {
        opb_rs2   = 3'd0,
        opb_i_imm = 3'd1,
        opb_s_imm = 3'd2,
        opb_b_imm = 3'd3,
        opb_u_imm = 3'd4,
        opb_j_imm = 3'd5
    } opb_select_e;

    typedef struct packed {
        alu_func_e   func;
        opa_select_e opa_select;
        opb_select_e opb_select;
        word_t       rs1_value;
        word_t       rs2_value;
        word_t       pc;
        word_t       inst;
        tag_t        tag;
    } issue_packet_t;

    typedef struct packed {
        tag_t  tag;
        word_t data;
    } alu_result_t;

    localparam word_t opa_marker  = 32'hdeadface;
    localparam word_t opb_marker  = 32'hfacefeed;
    localparam word_t func_marker = 32'hfacebeec;

    typedef enum logic [1:0] {lane_idle, lane_issue_hold, lane_result_wait, lane_result_release}
        lane_state_e;
    typedef enum logic [1:0] {arb_scan, arb_offer, arb_drop, arb_settle} arb_state_e;
    typedef enum logic [1:0] {disp_idle, disp_forward, disp_release, disp_settle}
        dispatch_state_e;

endpackage

`default_nettype wire

//--- logic/issue_dispatch.sv
`default_nettype none

module issue_dispatch (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    issue_req,
    input  exec_pkg::issue_packet_t issue_packet,
    output logic                    issue_ack,
    lane_issue_if.dispatch          lanes [exec_pkg::num_lanes]
);
    import exec_pkg::*;

    dispatch_state_e          state;
    logic [lane_idx_bits-1:0] sel;
    logic [lane_idx_bits-1:0] first_idle;
    logic                     any_idle;
    logic                     lane_req;
    logic [num_lanes-1:0]     idle_vec;
    logic [num_lanes-1:0]     ack_vec;
    issue_packet_t            packet_r;

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        assign idle_vec[i]     = lanes[i].idle;
        assign ack_vec[i]      = lanes[i].ack;
        assign lanes[i].req    = lane_req && (sel == lane_idx_bits'(i));
        assign lanes[i].packet = packet_r;
    end

    // lowest index wins, so walk downward
    always_comb begin
        any_idle   = 1'b0;
        first_idle = '0;
        for (int i = num_lanes - 1; i >= 0; i--) begin
            if (idle_vec[i]) begin
                any_idle   = 1'b1;
                first_idle = lane_idx_bits'(i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= disp_idle;
            sel       <= '0;
            lane_req  <= 1'b0;
            issue_ack <= 1'b0;
        end else begin
            case (state)
                disp_idle: begin
                    if (issue_req && any_idle) begin
                        sel      <= first_idle;   // choice held until handshake done
                        lane_req <= 1'b1;
                        state    <= disp_forward;
                    end
                end
                disp_forward: begin
                    if (ack_vec[sel]) begin
                        issue_ack <= 1'b1;
                        state     <= disp_release;
                    end
                end
                disp_release: begin
                    if (!issue_req) begin
                        lane_req <= 1'b0;
                        state    <= disp_settle;
                    end
                end
                disp_settle: begin
                    if (!ack_vec[sel]) begin
                        issue_ack <= 1'b0;
                        state     <= disp_idle;
                    end
                end
                default: state <= disp_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == disp_idle && issue_req && any_idle) packet_r <= issue_packet;
    end

endmodule

`default_nettype wire

//--- logic/lane_issue_if.sv
`default_nettype none

interface lane_issue_if;
    import exec_pkg::*;

    logic          req;
    logic          ack;
    logic          idle;    // lane can take a packet
    issue_packet_t packet;

    modport dispatch (
        output req, packet,
        input  ack, idle
    );

    modport lane (
        input  req, packet,
        output ack, idle
    );

endinterface

`default_nettype wire

//--- logic/lane_result_if.sv
`default_nettype none

interface lane_result_if;
    import exec_pkg::*;

    logic        req;
    logic        ack;
    alu_result_t result;

    modport lane (
        output req, result,
        input  ack
    );

    modport arbiter (
        input  req, result,
        output ack
    );

endinterface

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module alu_cluster_tb -f list.f

sim_out=$(./obj_dir/Valu_cluster_tb || true)
echo "$sim_out"

if grep -q -F '>>> PASS' <<< "$sim_out"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- verification/alu_cluster_tb.sv
`default_nettype none

module alu_cluster_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import exec_pkg::*;

    localparam int func_packets   = 10 * 6;
    localparam int select_packets = 4 * 6 * 2;
    localparam int random_packets = 100;
    localparam int total_packets  = func_packets + select_packets + num_lanes + 1 + random_packets;
    localparam int cycle_limit    = total_packets * 40 + 200;   // 40 covers issue, ack delay, drain

    logic          clock;
    logic          reset;
    logic          issue_req;
    issue_packet_t issue_packet;
    logic          issue_ack;
    logic          result_req;
    logic          result_ack;
    tag_t          result_tag;
    word_t         result_data;

    integer seed;
    int     cycle_count = 0;
    int     outstanding_count;
    logic   ack_enable;
    tag_t   next_tag;
    logic   outstanding [2**tag_bits];
    word_t  expected [2**tag_bits];
    // sign boundaries, plus shift amounts above 31
    word_t  a_vals [6] = '{32'h0, 32'h1, 32'h7fffffff, 32'h80000000, 32'hffffffff, 32'h12345678};
    word_t  b_vals [6] = '{32'hffffffff, 32'h80000000, 32'h1, 32'h7fffffff, 32'd37, 32'h00000123};

    alu_cluster u_alu_cluster (
        .clock        (clock),
        .reset        (reset),
        .issue_req    (issue_req),
        .issue_packet (issue_packet),
        .issue_ack    (issue_ack),
        .result_req   (result_req),
        .result_ack   (result_ack),
        .result_tag   (result_tag),
        .result_data  (result_data)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic word_t sign_extend(word_t v, int bits);
        logic signed [xlen-1:0] s;
        s = v << (xlen - bits);
        return s >>> (xlen - bits);
    endfunction

    function automatic word_t expected_result(issue_packet_t p);
        word_t                  a;
        word_t                  b;
        word_t                  inst;
        logic signed [xlen-1:0] sa;
        inst = p.inst;
        case (p.opa_select)
            opa_rs1:  a = p.rs1_value;
            opa_npc:  a = p.pc + 32'd4;
            opa_pc:   a = p.pc;
            opa_zero: a = 32'd0;
            default:  a = opa_marker;
        endcase
        case (p.opb_select)
            opb_rs2:   b = p.rs2_value;
            opb_i_imm: b = sign_extend(word_t'(inst[31:20]), 12);
            opb_s_imm: b = sign_extend(word_t'({inst[31:25], inst[11:7]}), 12);
            opb_b_imm: b = sign_extend(word_t'({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}), 13);
            opb_u_imm: b = inst & 32'hfffff000;
            opb_j_imm: b = sign_extend(word_t'({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}), 21);
            default:   b = opb_marker;
        endcase
        sa = a;
        case (p.func)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return sa >>> b[4:0];
            default:  return func_marker;
        endcase
    endfunction

    function automatic int rand_below(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic issue_packet_t random_packet();
        issue_packet_t p;
        p.func       = alu_func_e'(rand_below(10));
        p.opa_select = opa_select_e'(rand_below(4));
        p.opb_select = opb_select_e'(rand_below(6));
        p.rs1_value  = $random(seed);
        p.rs2_value  = $random(seed);
        p.pc         = $random(seed);
        p.inst       = $random(seed);
        p.tag        = '0;
        return p;
    endfunction

    task automatic fail_value(string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic fail_plain(string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_tag(tag_t got);
        if (!outstanding[got]) fail_value($sformatf("tag %0d returned but not outstanding", got));
    endtask

    task automatic check_data(word_t got, word_t want);
        if (got !== want) fail_value($sformatf("result 0x%08h, expected 0x%08h", got, want));
    endtask

    // scoreboard entry made before req rises
    task automatic start_issue(issue_packet_t p);
        while (outstanding[next_tag]) next_tag++;
        p.tag = next_tag;
        next_tag++;
        expected[p.tag]    = expected_result(p);
        outstanding[p.tag] = 1'b1;
        outstanding_count++;
        @(negedge clock);
        issue_packet = p;
        issue_req    = 1'b1;
    endtask

    task automatic finish_issue();
        while (!issue_ack) @(negedge clock);
        issue_req = 1'b0;
        while (issue_ack) @(negedge clock);
    endtask

    // result port responder and compare
    initial begin
        int delay;
        result_ack = 1'b0;
        forever begin
            @(negedge clock);
            if (result_req && ack_enable) begin
                check_tag(result_tag);
                check_data(result_data, expected[result_tag]);
                outstanding[result_tag] = 1'b0;
                outstanding_count--;
                delay = rand_below(4);
                repeat (delay) @(negedge clock);
                result_ack = 1'b1;
                while (result_req) @(negedge clock);
                result_ack = 1'b0;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            fail_plain($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        issue_packet_t p;
        seed              = 32'h42f786af;
        reset             = 1'b1;
        issue_req         = 1'b0;
        issue_packet      = '0;
        ack_enable        = 1'b1;
        next_tag          = '0;
        outstanding_count = 0;
        for (int i = 0; i < 2**tag_bits; i++) outstanding[i] = 1'b0;
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        if (issue_ack !== 1'b0 || result_req !== 1'b0) fail_value("handshake outputs high after reset");

        for (int f = 0; f < 10; f++) begin
            for (int i = 0; i < 6; i++) begin
                p            = random_packet();
                p.func       = alu_func_e'(f);
                p.opa_select = opa_rs1;
                p.opb_select = opb_rs2;
                p.rs1_value  = a_vals[i];
                p.rs2_value  = b_vals[i];
                start_issue(p);
                finish_issue();
            end
        end

        // every select, random instruction words
        for (int a = 0; a < 4; a++) begin
            for (int b = 0; b < 6; b++) begin
                for (int r = 0; r < 2; r++) begin
                    p            = random_packet();
                    p.func       = (r == 0) ? alu_add : alu_xor;
                    p.opa_select = opa_select_e'(a);
                    p.opb_select = opb_select_e'(b);
                    start_issue(p);
                    finish_issue();
                end
            end
        end

        // fill every lane with results held back
        while (outstanding_count != 0) @(negedge clock);
        ack_enable = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            start_issue(random_packet());
            finish_issue();
        end
        start_issue(random_packet());
        repeat (20) begin
            @(negedge clock);
            if (issue_ack) fail_value("issue_ack raised while every lane was busy");
        end
        ack_enable = 1'b1;
        finish_issue();

        for (int n = 0; n < random_packets; n++) begin
            start_issue(random_packet());
            finish_issue();
            repeat (rand_below(3)) @(negedge clock);
        end

        for (int w = 0; w < 200 && outstanding_count != 0; w++) @(negedge clock);
        if (outstanding_count != 0) begin
            fail_plain($sformatf("%0d issued tags never came back", outstanding_count));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
